// File: verilog.f
+incdir+hdl
hdl/sdram_pkg.sv
hdl/refresh_timer.sv
hdl/bank_tracker.sv
hdl/cmd_sequencer.sv
hdl/sdram_pins.sv
hdl/sdram_controller.sv
tb/sdram_model.sv
tb/tb_sdram_controller.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_sdram_controller -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Result: PASSED"

// File: tb/tb_sdram_controller.sv
`default_nettype none

`include "sdram_cfg.svh"

module tb_sdram_controller;

    localparam int RESET_CYCLES  = 16;
    localparam int N_ALT         = 3;
    localparam int N_DIRECTED    = 4 + 4 * N_ALT;
    localparam int N_RANDOM      = 200;
    localparam int N_REQUESTS    = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_TIME = (200 * N_REQUESTS + RESET_CYCLES) * 10;
    localparam int REF_WINDOW    = `SDRAM_REF_INTERVAL + 60;
    localparam int END_CYCLES    = 2 * REF_WINDOW + 40;
    localparam logic [31:0] SEED = 32'h3e80b3e1;

    localparam logic [`SDRAM_ADDR_W-1:0] ADDR_A     = {13'd7, 2'd0, 8'h21};
    localparam logic [`SDRAM_ADDR_W-1:0] ADDR_B     = {13'd11, 2'd2, 8'h40};
    localparam logic [`SDRAM_ADDR_W-1:0] GHOST_ADDR = {13'd12, 2'd3, 8'h77};

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic                     rw;
    logic [`SDRAM_ADDR_W-1:0] user_addr;
    logic [`SDRAM_DATA_W-1:0] data_in;
    logic                     busy;
    logic [`SDRAM_DATA_W-1:0] data_out;
    logic                     out_valid;
    logic                     sdram_cke;
    logic                     sdram_cs;
    logic                     sdram_ras;
    logic                     sdram_cas;
    logic                     sdram_we;
    logic                     sdram_dqm;
    logic [`SDRAM_BANK_W-1:0] sdram_ba;
    logic [`SDRAM_ROW_W-1:0]  sdram_a;
    logic [`SDRAM_DATA_W-1:0] sdram_dqo;
    logic                     sdram_dq_oe;
    logic [`SDRAM_DATA_W-1:0] sdram_dqi;

    bit                       wr_seen;
    logic [`SDRAM_ADDR_W-1:0] wr_key;
    logic [`SDRAM_DATA_W-1:0] wr_word;
    bit                       ref_seen;
    int                       model_errors;

    // reference memory and expected responses in acceptance order
    logic [`SDRAM_DATA_W-1:0] ref_mem [logic [`SDRAM_ADDR_W-1:0]];
    logic [`SDRAM_DATA_W-1:0] exp_rd_data [$];
    logic [`SDRAM_ADDR_W-1:0] exp_wr_addr [$];
    logic [`SDRAM_DATA_W-1:0] exp_wr_data [$];
    logic [`SDRAM_DATA_W-1:0] exp_word;
    logic [`SDRAM_ADDR_W-1:0] exp_addr;
    logic [31:0]              rng;
    int                       check_errors;
    int                       reads_accepted;
    int                       reads_done;
    int                       ref_count;
    int                       since_ref;
    int                       cycle_count;
    bit                       rst_prev;

    sdram_controller dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .rw          (rw),
        .user_addr   (user_addr),
        .data_in     (data_in),
        .busy        (busy),
        .data_out    (data_out),
        .out_valid   (out_valid),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_dqm   (sdram_dqm),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe),
        .sdram_dqi   (sdram_dqi)
    );

    sdram_model model_i (
        .clk      (clk),
        .rst      (rst),
        .cke      (sdram_cke),
        .cs       (sdram_cs),
        .ras      (sdram_ras),
        .cas      (sdram_cas),
        .we       (sdram_we),
        .ba       (sdram_ba),
        .a        (sdram_a),
        .dqo      (sdram_dqo),
        .dq_oe    (sdram_dq_oe),
        .dqi      (sdram_dqi),
        .wr_seen  (wr_seen),
        .wr_key   (wr_key),
        .wr_word  (wr_word),
        .ref_seen (ref_seen),
        .errors   (model_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic send_request(input logic op, input logic [`SDRAM_ADDR_W-1:0] addr,
                                input logic [`SDRAM_DATA_W-1:0] word);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        in_valid  = 1'b1;
        rw        = op;
        user_addr = addr;
        data_in   = word;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // request the DUT has to ignore
    task automatic pulse_while_busy(input logic op, input logic [`SDRAM_ADDR_W-1:0] addr,
                                    input logic [`SDRAM_DATA_W-1:0] word);
        assert (busy) else begin
            $display("%0t: busy was low when the ignored request was driven", $time);
            check_errors++;
        end
        in_valid  = 1'b1;
        rw        = op;
        user_addr = addr;
        data_in   = word;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic report_counts();
        $display("errors: %0d in checks, %0d in command protocol, %0d reads returned",
                 check_errors, model_errors, reads_done);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        report_counts();
        $display("Result: FAILED");
        $finish;
    end

    // pins and out_valid while in reset and in the cycle it falls
    always @(posedge clk) begin
        if (rst_prev) begin
            assert (!out_valid) else begin
                $display("error %0t out_valid got %b expected 0", $time, out_valid);
                check_errors++;
            end
            assert ({sdram_cs, sdram_ras, sdram_cas, sdram_we} == 4'b0111) else begin
                $display("error %0t sdram_cs/ras/cas/we got %b expected 0111", $time,
                         {sdram_cs, sdram_ras, sdram_cas, sdram_we});
                check_errors++;
            end
            assert (!sdram_dq_oe && !sdram_cke) else begin
                $display("error %0t sdram_dq_oe/sdram_cke got %b%b expected 00", $time,
                         sdram_dq_oe, sdram_cke);
                check_errors++;
            end
        end
        rst_prev <= rst;
    end

    // data mask stays low, full words only
    always @(posedge clk) begin
        assert (!sdram_dqm) else begin
            $display("error %0t sdram_dqm got %b expected 0", $time, sdram_dqm);
            check_errors++;
        end
    end

    // acceptance and read responses
    always @(posedge clk) begin
        if (!rst && in_valid && !busy) begin
            if (rw) begin
                ref_mem[user_addr] = data_in;
                exp_wr_addr.push_back(user_addr);
                exp_wr_data.push_back(data_in);
            end else begin
                exp_rd_data.push_back(ref_mem[user_addr]);
                reads_accepted++;
            end
        end
        if (out_valid) begin
            reads_done++;
            assert (exp_rd_data.size() != 0) else begin
                $display("%0t: out_valid with no read outstanding", $time);
                check_errors++;
            end
            if (exp_rd_data.size() != 0) begin
                exp_word = exp_rd_data.pop_front();
                assert (data_out == exp_word) else begin
                    $display("error %0t data_out got %h expected %h", $time, data_out, exp_word);
                    check_errors++;
                end
            end
        end
    end

    // writes seen by the model against accepted writes
    always @(posedge clk) begin
        if (wr_seen) begin
            assert (wr_key != GHOST_ADDR) else begin
                $display("%0t: a write reached the address of an ignored request", $time);
                check_errors++;
            end
            assert (exp_wr_addr.size() != 0) else begin
                $display("%0t: write on the pins with no write outstanding", $time);
                check_errors++;
            end
            if (exp_wr_addr.size() != 0) begin
                exp_addr = exp_wr_addr.pop_front();
                exp_word = exp_wr_data.pop_front();
                assert (wr_key == exp_addr) else begin
                    $display("error %0t wr_key got %h expected %h", $time, wr_key, exp_addr);
                    check_errors++;
                end
                assert (wr_word == exp_word) else begin
                    $display("error %0t sdram_dqo got %h expected %h", $time, wr_word, exp_word);
                    check_errors++;
                end
            end
        end
    end

    // refresh spacing
    always @(posedge clk) begin
        if (rst) begin
            since_ref   = 0;
            cycle_count = 0;
        end else begin
            cycle_count++;
            if (ref_seen) begin
                since_ref = 0;
                ref_count++;
            end else begin
                since_ref++;
            end
            assert (since_ref <= REF_WINDOW) else begin
                $display("%0t: no REFRESH within %0d cycles", $time, REF_WINDOW);
                check_errors++;
                since_ref = 0;
            end
        end
    end

    initial begin
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_ADDR_W-1:0] addr;
        logic                     op;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        rng       = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // write then read back on the open row
        rng = xorshift32(rng);
        send_request(1'b1, ADDR_A, rng);
        send_request(1'b0, ADDR_A, '0);

        // two rows in one bank force precharge and activate
        for (int i = 0; i < N_ALT; i++) begin
            rng = xorshift32(rng);
            send_request(1'b1, {13'd5, 2'd1, 8'(i)}, rng);
            rng = xorshift32(rng);
            send_request(1'b1, {13'd9, 2'd1, 8'(i)}, rng);
            send_request(1'b0, {13'd5, 2'd1, 8'(i)}, '0);
            send_request(1'b0, {13'd9, 2'd1, 8'(i)}, '0);
        end

        // pulses during busy must be dropped
        rng = xorshift32(rng);
        send_request(1'b1, ADDR_B, rng);
        pulse_while_busy(1'b1, GHOST_ADDR, 32'hdeadbeef);
        send_request(1'b0, ADDR_B, '0);
        pulse_while_busy(1'b0, GHOST_ADDR, '0);

        // random mix over rows 1, 5, 9, 13 in all banks
        for (int n = 0; n < N_RANDOM; n++) begin
            rng  = xorshift32(rng);
            row  = {{(`SDRAM_ROW_W - 4){1'b0}}, rng[1:0], 2'b01};
            addr = {row, rng[3:2], 4'h0, rng[7:4]};
            // only read what has been written
            op   = rng[8] || !ref_mem.exists(addr);
            rng  = xorshift32(rng);
            send_request(op, addr, rng);
        end

        while (exp_rd_data.size() != 0 || exp_wr_addr.size() != 0) begin
            @(posedge clk);
        end
        while (cycle_count < END_CYCLES) begin
            @(posedge clk);
        end

        assert (reads_done == reads_accepted) else begin
            $display("error %0t out_valid count got %0d expected %0d", $time,
                     reads_done, reads_accepted);
            check_errors++;
        end
        assert (ref_count >= 2) else begin
            $display("%0t: only %0d refreshes in a run of two intervals", $time, ref_count);
            check_errors++;
        end

        report_counts();
        if (check_errors + model_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/sdram_model.sv
`default_nettype none

`include "sdram_cfg.svh"

module sdram_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cke,
    input  logic                     cs,
    input  logic                     ras,
    input  logic                     cas,
    input  logic                     we,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_DATA_W-1:0] dqo,
    input  logic                     dq_oe,
    output logic [`SDRAM_DATA_W-1:0] dqi,
    output bit                       wr_seen,
    output logic [`SDRAM_ADDR_W-1:0] wr_key,
    output logic [`SDRAM_DATA_W-1:0] wr_word,
    output bit                       ref_seen,
    output int                       errors
);

    // pin encodings, cs ras cas we
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;

    logic [3:0]               cmd;
    logic [`SDRAM_ADDR_W-1:0] key;
    bit [`SDRAM_BANKS-1:0]    open_q;
    logic [`SDRAM_ROW_W-1:0]  row_q [`SDRAM_BANKS];
    logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_ADDR_W-1:0]];
    int                       gap_q;
    int                       min_gap_q;

    assign cmd = {cs, ras, cas, we};

    // word address as the controller sees it, row | bank | column
    assign key = {row_q[ba], ba, a[9:2]};

    always @(posedge clk) begin
        wr_seen  <= 1'b0;
        ref_seen <= 1'b0;
        if (rst) begin
            // no decode while in reset
            dqi   <= '0;
            gap_q <= gap_q + 1;
        end else if (cs || cmd == CMD_NOP) begin
            gap_q <= gap_q + 1;
        end else begin
            assert (cke) else begin
                $display("%0t: command issued while cke is low", $time);
                errors++;
            end
            assert (gap_q >= min_gap_q) else begin
                $display("%0t: command %b came only %0d cycles after the previous one",
                         $time, cmd, gap_q);
                errors++;
            end
            gap_q     <= 1;
            min_gap_q <= (cmd == CMD_REFRESH) ? `SDRAM_T_REF + 1 : `SDRAM_T_CAS + 1;
            case (cmd)
                CMD_ACTIVE: begin
                    assert (!open_q[ba]) else begin
                        $display("%0t: ACTIVE to bank %0d which is still open", $time, ba);
                        errors++;
                    end
                    open_q[ba] <= 1'b1;
                    row_q[ba]  <= a;
                end
                CMD_PRECHARGE: begin
                    // A10 selects all banks
                    if (a[10]) begin
                        open_q <= '0;
                    end else begin
                        open_q[ba] <= 1'b0;
                    end
                end
                CMD_READ: begin
                    assert (open_q[ba]) else begin
                        $display("%0t: READ to closed bank %0d", $time, ba);
                        errors++;
                    end
                    // data stays on dqi until the next read
                    dqi <= mem.exists(key) ? mem[key] : {9'h1b3, key};
                end
                CMD_WRITE: begin
                    assert (open_q[ba] && dq_oe) else begin
                        $display("%0t: WRITE to closed bank %0d or without dq_oe", $time, ba);
                        errors++;
                    end
                    mem[key] = dqo;
                    wr_seen  <= 1'b1;
                    wr_key   <= key;
                    wr_word  <= dqo;
                end
                CMD_REFRESH: begin
                    assert (open_q == '0) else begin
                        $display("%0t: REFRESH while banks %b are open", $time, open_q);
                        errors++;
                    end
                    ref_seen <= 1'b1;
                end
                default: begin
                    $display("%0t: unknown command %b on the pins", $time, cmd);
                    errors++;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/sdram_controller.sv
`default_nettype none

`include "sdram_cfg.svh"

module sdram_controller
    import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // user port
    input  logic                     in_valid,
    input  logic                     rw,
    input  logic [`SDRAM_ADDR_W-1:0] user_addr,
    input  logic [`SDRAM_DATA_W-1:0] data_in,
    output logic                     busy,
    output logic [`SDRAM_DATA_W-1:0] data_out,
    output logic                     out_valid,
    // sdram pins
    output logic                     sdram_cke,
    output logic                     sdram_cs,
    output logic                     sdram_ras,
    output logic                     sdram_cas,
    output logic                     sdram_we,
    output logic                     sdram_dqm,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_DATA_W-1:0] sdram_dqo,
    output logic                     sdram_dq_oe,
    input  logic [`SDRAM_DATA_W-1:0] sdram_dqi
);

    logic                     ref_req, ref_ack;
    sdram_addr_u              q_addr;
    logic                     row_hit, bank_open;
    logic                     act_en, pre_en, pre_all;
    logic [`SDRAM_BANK_W-1:0] pre_bank;
    logic                     cke;
    sdram_cmd_e               cmd;
    logic [`SDRAM_BANK_W-1:0] ba;
    logic [`SDRAM_ROW_W-1:0]  a;
    logic [`SDRAM_DATA_W-1:0] wdata, rd_data;
    logic                     wr_en;

    // no byte masking, full words only
    assign sdram_dqm = 1'b0;

    refresh_timer refresh_timer_i (
        .clk     (clk),
        .rst     (rst),
        .ref_ack (ref_ack),
        .ref_req (ref_req)
    );

    bank_tracker bank_tracker_i (
        .clk       (clk),
        .rst       (rst),
        .addr      (q_addr),
        .act_en    (act_en),
        .pre_en    (pre_en),
        .pre_all   (pre_all),
        .pre_bank  (pre_bank),
        .row_hit   (row_hit),
        .bank_open (bank_open)
    );

    cmd_sequencer cmd_sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .rw        (rw),
        .user_addr (user_addr),
        .data_in   (data_in),
        .busy      (busy),
        .out_valid (out_valid),
        .data_out  (data_out),
        .ref_req   (ref_req),
        .ref_ack   (ref_ack),
        .q_addr    (q_addr),
        .row_hit   (row_hit),
        .bank_open (bank_open),
        .act_en    (act_en),
        .pre_en    (pre_en),
        .pre_all   (pre_all),
        .pre_bank  (pre_bank),
        .cke       (cke),
        .cmd       (cmd),
        .ba        (ba),
        .a         (a),
        .wdata     (wdata),
        .wr_en     (wr_en),
        .rd_data   (rd_data)
    );

    sdram_pins sdram_pins_i (
        .clk         (clk),
        .rst         (rst),
        .cke_in      (cke),
        .cmd         (cmd),
        .ba_in       (ba),
        .a_in        (a),
        .wdata       (wdata),
        .wr_en       (wr_en),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe),
        .sdram_dqi   (sdram_dqi),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: hdl/sdram_pins.sv
`default_nettype none

`include "sdram_cfg.svh"

module sdram_pins
    import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cke_in,
    input  sdram_cmd_e               cmd,
    input  logic [`SDRAM_BANK_W-1:0] ba_in,
    input  logic [`SDRAM_ROW_W-1:0]  a_in,
    input  logic [`SDRAM_DATA_W-1:0] wdata,
    input  logic                     wr_en,
    output logic                     sdram_cke,
    output logic                     sdram_cs,
    output logic                     sdram_ras,
    output logic                     sdram_cas,
    output logic                     sdram_we,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_DATA_W-1:0] sdram_dqo,
    output logic                     sdram_dq_oe,
    input  logic [`SDRAM_DATA_W-1:0] sdram_dqi,
    output logic [`SDRAM_DATA_W-1:0] rd_data
);

    sdram_cmd_e cmd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_cke   <= 1'b0;
            sdram_dq_oe <= 1'b0;
            cmd_q       <= CMD_NOP;
        end else begin
            sdram_cke   <= cke_in;
            sdram_dq_oe <= wr_en;
            cmd_q       <= cmd;
        end
    end

    // address, write data and read capture
    always_ff @(posedge clk) begin
        sdram_ba  <= ba_in;
        sdram_a   <= a_in;
        sdram_dqo <= wdata;
        rd_data   <= sdram_dqi;
    end

    assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = cmd_q;

endmodule

`default_nettype wire

// File: hdl/cmd_sequencer.sv
`default_nettype none

`include "sdram_cfg.svh"

module cmd_sequencer
    import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  logic                     rw,
    input  logic [`SDRAM_ADDR_W-1:0] user_addr,
    input  logic [`SDRAM_DATA_W-1:0] data_in,
    output logic                     busy,
    output logic                     out_valid,
    output logic [`SDRAM_DATA_W-1:0] data_out,
    input  logic                     ref_req,
    output logic                     ref_ack,
    output sdram_addr_u              q_addr,
    input  logic                     row_hit,
    input  logic                     bank_open,
    output logic                     act_en,
    output logic                     pre_en,
    output logic                     pre_all,
    output logic [`SDRAM_BANK_W-1:0] pre_bank,
    output logic                     cke,
    output sdram_cmd_e               cmd,
    output logic [`SDRAM_BANK_W-1:0] ba,
    output logic [`SDRAM_ROW_W-1:0]  a,
    output logic [`SDRAM_DATA_W-1:0] wdata,
    output logic                     wr_en,
    input  logic [`SDRAM_DATA_W-1:0] rd_data
);

    seq_state_e                state_q, state_d;
    seq_state_e                next_q, next_d;
    logic [`SDRAM_DELAY_W-1:0] delay_q, delay_d;
    logic                      ready_q, cke_q, out_valid_q;
    logic                      pre_all_q, pre_all_d;
    logic [`SDRAM_BANK_W-1:0]  pre_bank_q, pre_bank_d;
    logic                      accept, take, read_done;

    // one-entry queue
    logic                      saved_rw_q;
    sdram_addr_u               saved_addr_q;
    logic [`SDRAM_DATA_W-1:0]  saved_data_q;

    // operation in progress
    logic                      rw_op_q;
    sdram_addr_u               addr_q;
    logic [`SDRAM_DATA_W-1:0]  data_q, rdata_q;

    logic [`SDRAM_ROW_W-1:0]   col_a;

    assign accept = ready_q && in_valid;

    // column on A[9:2], A10 low so no auto precharge
    assign col_a = {{(`SDRAM_ROW_W - `SDRAM_COL_W - 2){1'b0}}, addr_q.f.col, 2'b00};

    // decision uses the queue in IDLE, later commands use the working copy
    assign q_addr = (state_q == ST_IDLE) ? saved_addr_q : addr_q;

    always_comb begin
        state_d    = state_q;
        next_d     = next_q;
        delay_d    = delay_q;
        pre_all_d  = pre_all_q;
        pre_bank_d = pre_bank_q;
        take       = 1'b0;
        read_done  = 1'b0;
        ref_ack    = 1'b0;
        act_en     = 1'b0;
        pre_en     = 1'b0;
        wr_en      = 1'b0;
        cmd        = CMD_NOP;
        ba         = '0;
        a          = '0;
        case (state_q)
            ST_INIT: begin
                state_d = ST_IDLE;
            end
            ST_IDLE: begin
                if (ref_req) begin
                    // close everything before auto-refresh
                    ref_ack   = 1'b1;
                    pre_all_d = 1'b1;
                    state_d   = ST_PRECHARGE;
                    next_d    = ST_REFRESH;
                end else if (!ready_q) begin
                    take = 1'b1;
                    if (row_hit) begin
                        state_d = saved_rw_q ? ST_WRITE : ST_READ;
                    end else if (bank_open) begin
                        pre_all_d  = 1'b0;
                        pre_bank_d = saved_addr_q.f.bank;
                        state_d    = ST_PRECHARGE;
                        next_d     = ST_ACTIVATE;
                    end else begin
                        state_d = ST_ACTIVATE;
                    end
                end
            end
            ST_WAIT: begin
                delay_d = delay_q - 1'b1;
                if (delay_q == '0) begin
                    state_d = next_q;
                end
            end
            ST_ACTIVATE: begin
                cmd     = CMD_ACTIVE;
                ba      = addr_q.f.bank;
                a       = addr_q.f.row;
                act_en  = 1'b1;
                delay_d = `SDRAM_DELAY_W'(`SDRAM_T_ACT);
                next_d  = rw_op_q ? ST_WRITE : ST_READ;
                state_d = ST_WAIT;
            end
            ST_READ: begin
                cmd     = CMD_READ;
                ba      = addr_q.f.bank;
                a       = col_a;
                delay_d = `SDRAM_DELAY_W'(`SDRAM_T_CAS);
                next_d  = ST_READ_RES;
                state_d = ST_WAIT;
            end
            ST_READ_RES: begin
                read_done = 1'b1;
                state_d   = ST_IDLE;
            end
            ST_WRITE: begin
                cmd     = CMD_WRITE;
                ba      = addr_q.f.bank;
                a       = col_a;
                wr_en   = 1'b1;
                delay_d = `SDRAM_DELAY_W'(`SDRAM_T_CAS);
                next_d  = ST_IDLE;
                state_d = ST_WAIT;
            end
            ST_PRECHARGE: begin
                cmd     = CMD_PRECHARGE;
                ba      = pre_bank_q;
                a[10]   = pre_all_q;
                pre_en  = 1'b1;
                delay_d = `SDRAM_DELAY_W'(`SDRAM_T_PRE);
                state_d = ST_WAIT;
            end
            ST_REFRESH: begin
                cmd     = CMD_REFRESH;
                delay_d = `SDRAM_DELAY_W'(`SDRAM_T_REF);
                next_d  = ST_IDLE;
                state_d = ST_WAIT;
            end
            default: begin
                state_d = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_INIT;
            next_q      <= ST_IDLE;
            delay_q     <= '0;
            ready_q     <= 1'b0;
            cke_q       <= 1'b0;
            out_valid_q <= 1'b0;
            pre_all_q   <= 1'b0;
        end else begin
            state_q     <= state_d;
            next_q      <= next_d;
            delay_q     <= delay_d;
            pre_all_q   <= pre_all_d;
            out_valid_q <= read_done;
            if (state_q == ST_INIT) begin
                cke_q <= 1'b1;
            end
            // queue frees on init or when IDLE pops it
            if (state_q == ST_INIT || take) begin
                ready_q <= 1'b1;
            end else if (accept) begin
                ready_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            saved_rw_q        <= rw;
            saved_addr_q.flat <= user_addr;
            saved_data_q      <= data_in;
        end
        if (take) begin
            rw_op_q <= saved_rw_q;
            addr_q  <= saved_addr_q;
            data_q  <= saved_data_q;
        end
        if (read_done) begin
            rdata_q <= rd_data;
        end
        pre_bank_q <= pre_bank_d;
    end

    assign busy      = !ready_q;
    assign out_valid = out_valid_q;
    assign data_out  = rdata_q;
    assign cke       = cke_q;
    assign wdata     = data_q;
    assign pre_all   = pre_all_q;
    assign pre_bank  = pre_bank_q;

endmodule

`default_nettype wire

// File: hdl/bank_tracker.sv
`default_nettype none

`include "sdram_cfg.svh"

module bank_tracker
    import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  sdram_addr_u              addr,
    input  logic                     act_en,
    input  logic                     pre_en,
    input  logic                     pre_all,
    input  logic [`SDRAM_BANK_W-1:0] pre_bank,
    output logic                     row_hit,
    output logic                     bank_open
);

    logic [`SDRAM_BANKS-1:0] open_q;
    logic [`SDRAM_ROW_W-1:0] row_q [`SDRAM_BANKS];

    // open flags per bank
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (pre_en) begin
                if (pre_all) begin
                    open_q <= '0;
                end else begin
                    open_q[pre_bank] <= 1'b0;
                end
            end
            if (act_en) begin
                open_q[addr.f.bank] <= 1'b1;
            end
        end
    end

    // row only meaningful while the open flag is set
    always_ff @(posedge clk) begin
        if (act_en) begin
            row_q[addr.f.bank] <= addr.f.row;
        end
    end

    assign bank_open = open_q[addr.f.bank];
    assign row_hit   = bank_open && (row_q[addr.f.bank] == addr.f.row);

endmodule

`default_nettype wire

// File: hdl/refresh_timer.sv
`default_nettype none

`include "sdram_cfg.svh"

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic ref_ack,
    output logic ref_req
);

    logic [9:0] ref_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt_q <= '0;
            ref_req   <= 1'b0;
        end else begin
            if (ref_cnt_q > 10'(`SDRAM_REF_INTERVAL)) begin
                // new interval starts, a fresh request wins over a late ack
                ref_cnt_q <= '0;
                ref_req   <= 1'b1;
            end else begin
                ref_cnt_q <= ref_cnt_q + 10'd1;
                if (ref_ack) begin
                    ref_req <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sdram_pkg.sv
`default_nettype none

`include "sdram_cfg.svh"

package sdram_pkg;

    // request address, flat for queueing and split for commands
    typedef union packed {
        logic [`SDRAM_ADDR_W-1:0] flat;
        struct packed {
            logic [`SDRAM_ROW_W-1:0]  row;
            logic [`SDRAM_BANK_W-1:0] bank;
            logic [`SDRAM_COL_W-1:0]  col;
        } f;
    } sdram_addr_u;

    // bit order is cs, ras, cas, we
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        ST_INIT      = 4'd0,
        ST_IDLE      = 4'd1,
        ST_WAIT      = 4'd2,
        ST_ACTIVATE  = 4'd3,
        ST_READ      = 4'd4,
        ST_READ_RES  = 4'd5,
        ST_WRITE     = 4'd6,
        ST_PRECHARGE = 4'd7,
        ST_REFRESH   = 4'd8
    } seq_state_e;

endpackage

`default_nettype wire

// File: hdl/sdram_cfg.svh
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// address split, row | bank | column
`define SDRAM_ROW_W   13
`define SDRAM_BANK_W  2
`define SDRAM_COL_W   8
`define SDRAM_ADDR_W  23
`define SDRAM_DATA_W  32
`define SDRAM_BANKS   4

// wait counts, n means n+1 cycles between commands
`define SDRAM_T_CAS   2
`define SDRAM_T_PRE   2
`define SDRAM_T_ACT   2
`define SDRAM_T_REF   6

// refresh counter limit in clocks
`define SDRAM_REF_INTERVAL 750
`define SDRAM_DELAY_W      4

`endif
